/* Bender.yml */
package:
  name: tag_gateway

sources:
  - logic/tag_pkg.sv
  - logic/tag_trace_rom.sv
  - logic/tag_trace_replay.sv
  - logic/tag_packet_serializer.sv
  - logic/tag_clock_slowdown.sv
  - logic/tag_gateway.sv
  - target: test
    files:
      - bench/tag_gateway_tb.sv

/* bench/tag_gateway_tb.sv */
module tag_gateway_tb
  import tag_pkg::*;
();

  localparam int num_rows_c    = 4;
  localparam int hdr_bits_c    = 10;
  localparam int wait_cycles_c = 5;
  localparam int settle_c      = 30;

  logic         clk_i;
  logic         rst_n_i;
  logic         en_i;
  logic         tag_data_o;
  tag_masters_t tag_en_o;
  logic         done_o;
  logic         error_o;
  logic         core_clk_en_o;

  // Row layout is masters, node, dnr, len, payload
  logic [18:0]  exp_rows [num_rows_c];
  logic [18:0]  got_q [$];

  logic [31:0]  lfsr_q = 32'h27a2;
  int           cycle_cnt = 0;
  int           timeout_limit;
  bit           timed_out = 1'b0;
  int           tests_run = 0;
  int           tests_failed = 0;

  int           reset_errs = 0;
  int           frame_errs = 0;
  int           illegal_errs = 0;
  int           done_errs = 0;
  int           slow_errs = 0;
  int           count_errs = 0;

  // Decoder and status monitor state
  bit           in_pkt = 1'b0;
  int           bit_idx = 0;
  tag_masters_t pkt_en;
  logic [31:0]  pkt_bits;
  bit           err_at_start;
  int           pkt_started = 0;
  bit           done_seen = 1'b0;
  bit           error_seen = 1'b0;
  int           done_age = 0;
  logic [3:0]   clk_win = '0;
  int           win_fill = 0;

  tag_gateway uut
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .en_i          (en_i),
    .tag_data_o    (tag_data_o),
    .tag_en_o      (tag_en_o),
    .done_o        (done_o),
    .error_o       (error_o),
    .core_clk_en_o (core_clk_en_o)
  );

  always #10 clk_i = ~clk_i;

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  always @(posedge clk_i)
  begin : drive_en_blk
    logic b0;
    logic b1;
    lfsr_q = lfsr_step(lfsr_q);
    b0     = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    b1     = lfsr_q[0];
    // Stall about one cycle in four
    en_i <= b0 | b1;
  end

  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAILED at %0t: %s expected %0h got %0h", $time, sig, exp, got);
  endtask

  task automatic report_test(input string name, input int errs);
    tests_run++;
    if (errs == 0)
    begin
      $display("test %-14s ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %-14s %0d errors", name, errs);
    end
  endtask

  task automatic check_cleared();
    if (tag_data_o !== 1'b0)
    begin
      report_mismatch("tag_data_o", 0, tag_data_o);
      reset_errs++;
    end
    if (tag_en_o !== '0)
    begin
      report_mismatch("tag_en_o", 0, tag_en_o);
      reset_errs++;
    end
    if (done_o !== 1'b0)
    begin
      report_mismatch("done_o", 0, done_o);
      reset_errs++;
    end
    if (error_o !== 1'b0)
    begin
      report_mismatch("error_o", 0, error_o);
      reset_errs++;
    end
  endtask

  //////////////////////////////////////////////////
  // Serial packet decoder
  //////////////////////////////////////////////////

  task automatic end_packet();
    logic [3:0] len;
    logic [3:0] node;
    logic [7:0] payload;
    len     = pkt_bits[9:6];
    node    = pkt_bits[4:1];
    payload = '0;
    // Payload starts right after the 10 header bits
    for (int i = 0; i < 8; i++)
    begin
      if (i < len)
        payload[i] = pkt_bits[hdr_bits_c + i];
    end
    if (pkt_bits[0] !== 1'b1)
    begin
      report_mismatch("tag_data_o start bit", 1, pkt_bits[0]);
      frame_errs++;
    end
    if (bit_idx != hdr_bits_c + len)
    begin
      report_mismatch("tag_en_o cycles", hdr_bits_c + len, bit_idx);
      frame_errs++;
    end
    if (len == 4'd12)
    begin
      $display("FAILED at %0t: a packet with the illegal length 12 went out", $time);
      illegal_errs++;
    end
    if (node == 4'd15 && !err_at_start)
    begin
      $display("FAILED at %0t: error_o was low when the packet to node 15 started", $time);
      illegal_errs++;
    end
    got_q.push_back({pkt_en, node, pkt_bits[5], len, payload});
  endtask

  task automatic decode_step();
    if (tag_en_o != '0)
    begin
      if (!in_pkt)
      begin
        in_pkt       = 1'b1;
        bit_idx      = 0;
        pkt_en       = tag_en_o;
        pkt_bits     = '0;
        err_at_start = error_o;
        pkt_started++;
      end
      else if (tag_en_o != pkt_en)
      begin
        report_mismatch("tag_en_o", pkt_en, tag_en_o);
        frame_errs++;
      end
      if (bit_idx < 32)
        pkt_bits[bit_idx] = tag_data_o;
      bit_idx++;
    end
    else
    begin
      if (tag_data_o !== 1'b0)
      begin
        report_mismatch("tag_data_o", 0, tag_data_o);
        frame_errs++;
      end
      if (in_pkt)
      begin
        in_pkt = 1'b0;
        end_packet();
      end
    end
  endtask

  task automatic watch_status();
    logic [2:0] ones;
    if (error_o)
      error_seen = 1'b1;
    else if (error_seen)
    begin
      $display("FAILED at %0t: error_o fell after it was set", $time);
      illegal_errs++;
    end
    if (done_o)
    begin
      if (!done_seen)
      begin
        done_seen = 1'b1;
        if (pkt_started != num_rows_c)
        begin
          report_mismatch("packets started at done_o", num_rows_c, pkt_started);
          done_errs++;
        end
      end
      // Full rate from the second cycle after done_o
      if (done_age >= 2 && core_clk_en_o !== 1'b1)
      begin
        report_mismatch("core_clk_en_o", 1, core_clk_en_o);
        slow_errs++;
      end
      done_age++;
    end
    else
    begin
      if (done_seen)
      begin
        $display("FAILED at %0t: done_o fell after it was set", $time);
        done_errs++;
      end
      clk_win = {clk_win[2:0], core_clk_en_o};
      if (win_fill < 4)
        win_fill++;
      ones = clk_win[0] + clk_win[1] + clk_win[2] + clk_win[3];
      if (win_fill == 4 && ones != 3'd1)
      begin
        report_mismatch("core_clk_en_o highs in 4 cycles", 1, ones);
        slow_errs++;
      end
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk_i)
  begin
    if (!rst_n_i)
    begin
      check_cleared();
    end
    else
    begin
      decode_step();
      watch_status();
    end
  end

  task automatic check_packet(input int row);
    logic [18:0] got;
    logic [18:0] exp;
    int          errs;
    got  = got_q[row];
    exp  = exp_rows[row];
    errs = 0;
    if (got[18:17] !== exp[18:17])
    begin
      report_mismatch($sformatf("packet %0d tag_en_o", row), exp[18:17], got[18:17]);
      errs++;
    end
    if (got[16:13] !== exp[16:13])
    begin
      report_mismatch($sformatf("packet %0d node", row), exp[16:13], got[16:13]);
      errs++;
    end
    if (got[12] !== exp[12])
    begin
      report_mismatch($sformatf("packet %0d dnr", row), exp[12], got[12]);
      errs++;
    end
    if (got[11:8] !== exp[11:8])
    begin
      report_mismatch($sformatf("packet %0d len", row), exp[11:8], got[11:8]);
      errs++;
    end
    if (got[7:0] !== exp[7:0])
    begin
      report_mismatch($sformatf("packet %0d payload", row), exp[7:0], got[7:0]);
      errs++;
    end
    report_test($sformatf("packet %0d", row), errs);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    clk_i   = 1'b0;
    rst_n_i = 1'b0;
    en_i    = 1'b0;

    // Legal sends in trace order with payloads cut to len bits
    exp_rows[0] = {2'b01, 4'd2, 1'b0, 4'd1, 8'h01};
    exp_rows[1] = {2'b01, 4'd2, 1'b1, 4'd8, 8'ha5};
    exp_rows[2] = {2'b11, 4'd9, 1'b1, 4'd5, 8'h16};
    exp_rows[3] = {2'b10, 4'd15, 1'b1, 4'd3, 8'h05};

    timeout_limit = wait_cycles_c;
    for (int r = 0; r < num_rows_c; r++)
    begin
      timeout_limit += hdr_bits_c + exp_rows[r][11:8];
    end
    timeout_limit = 4 * timeout_limit + 200;

    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_cleared();
    report_test("reset", reset_errs);

    for (int row = 0; row < num_rows_c && !timed_out; row++)
    begin
      while (got_q.size() <= row && cycle_cnt < timeout_limit)
        @(negedge clk_i);
      if (got_q.size() <= row)
      begin
        timed_out = 1'b1;
        $display("FAILED at %0t: timed out waiting for packet %0d", $time, row);
      end
      else
      begin
        check_packet(row);
      end
    end

    while (!done_o && cycle_cnt < timeout_limit)
      @(negedge clk_i);
    if (!done_o && !timed_out)
    begin
      timed_out = 1'b1;
      $display("FAILED at %0t: timed out waiting for done_o", $time);
    end
    if (timed_out)
      done_errs++;

    // Catch stray packets and the full-rate enable
    repeat (settle_c) @(negedge clk_i);
    @(posedge clk_i);
    if (got_q.size() != num_rows_c)
    begin
      $display("FAILED at %0t: saw %0d packets where %0d were expected",
               $time, got_q.size(), num_rows_c);
      count_errs++;
    end
    if (!error_seen)
    begin
      $display("FAILED at %0t: error_o never rose for the malformed entry", $time);
      illegal_errs++;
    end

    report_test("packet count", count_errs);
    report_test("framing", frame_errs);
    report_test("illegal entry", illegal_errs);
    report_test("completion", done_errs);
    report_test("slowdown", slow_errs);
    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* logic/tag_clock_slowdown.sv */
module tag_clock_slowdown
  import tag_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic done_i,
  output logic core_clk_en_o
);

  logic      done_meta_r;
  logic      done_sync_r;
  slow_cnt_t div_cnt_r;
  logic      div_tc;

  //////////////////////////////////////////////////
  // Done synchronizer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      done_meta_r <= 1'b0;
      done_sync_r <= 1'b0;
    end
    else
    begin
      done_meta_r <= done_i;
      done_sync_r <= done_meta_r;
    end
  end

  //////////////////////////////////////////////////
  // Divider
  //////////////////////////////////////////////////

  assign div_tc = (div_cnt_r == slow_cnt_t'(slowdown_ratio_c - 1));

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      div_cnt_r <= '0;
    end
    else if (div_tc)
    begin
      div_cnt_r <= '0;
    end
    else
    begin
      div_cnt_r <= div_cnt_r + 1'b1;
    end
  end

  // One pulse in every ratio cycles while programming, then full rate
  assign core_clk_en_o = done_sync_r | div_tc;

endmodule

/* logic/tag_gateway.sv */
module tag_gateway
  import tag_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         en_i,

  output logic         tag_data_o,
  output tag_masters_t tag_en_o,
  output logic         done_o,
  output logic         error_o,
  output logic         core_clk_en_o
);

  rom_addr_t    rom_addr;
  tag_entry_t   rom_data;

  logic         send_valid;
  logic         send_ready;
  tag_masters_t send_masters;
  tag_node_id_t send_node;
  logic         send_dnr;
  tag_len_t     send_len;
  tag_payload_t send_payload;

  logic         trace_done;

  //////////////////////////////////////////////////
  // Trace replay
  //////////////////////////////////////////////////

  tag_trace_rom trace_rom
  (
    .rom_addr_i (rom_addr),
    .rom_data_o (rom_data)
  );

  tag_trace_replay trace_replay
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .en_i           (en_i),
    .rom_addr_o     (rom_addr),
    .rom_data_i     (rom_data),
    .send_valid_o   (send_valid),
    .send_masters_o (send_masters),
    .send_node_o    (send_node),
    .send_dnr_o     (send_dnr),
    .send_len_o     (send_len),
    .send_payload_o (send_payload),
    .send_ready_i   (send_ready),
    .done_o         (trace_done),
    .error_o        (error_o)
  );

  //////////////////////////////////////////////////
  // Tag line and core clock enable
  //////////////////////////////////////////////////

  tag_packet_serializer packet_serializer
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (send_valid),
    .masters_i  (send_masters),
    .node_i     (send_node),
    .dnr_i      (send_dnr),
    .len_i      (send_len),
    .payload_i  (send_payload),
    .ready_o    (send_ready),
    .tag_data_o (tag_data_o),
    .tag_en_o   (tag_en_o)
  );

  tag_clock_slowdown clock_slowdown
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .done_i        (trace_done),
    .core_clk_en_o (core_clk_en_o)
  );

  assign done_o = trace_done;

endmodule

/* logic/tag_packet_serializer.sv */
module tag_packet_serializer
  import tag_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,

  input  logic         valid_i,
  input  tag_masters_t masters_i,
  input  tag_node_id_t node_i,
  input  logic         dnr_i,
  input  tag_len_t     len_i,
  input  tag_payload_t payload_i,
  output logic         ready_o,

  output logic         tag_data_o,
  output tag_masters_t tag_en_o
);

  ser_state_e   state_r;
  tag_bit_cnt_t cnt_r;
  tag_pkt_t     shift_r;
  tag_masters_t masters_r;
  logic         accept;

  assign ready_o = (state_r == ser_idle);
  assign accept  = valid_i && ready_o;

  //////////////////////////////////////////////////
  // Bit counter and state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= ser_idle;
      cnt_r   <= '0;
    end
    else
    begin
      case (state_r)
        ser_idle:
        begin
          if (accept)
          begin
            state_r <= ser_shift;
            cnt_r   <= tag_bit_cnt_t'(tag_pkt_hdr_width_c) + tag_bit_cnt_t'(len_i);
          end
        end
        ser_shift:
        begin
          cnt_r <= cnt_r - 1'b1;
          // Last bit on the wire this cycle
          if (cnt_r == tag_bit_cnt_t'(1))
          begin
            state_r <= ser_gap;
          end
        end
        // One quiet cycle between packets
        ser_gap:
        begin
          state_r <= ser_idle;
        end
        default:
        begin
          state_r <= ser_idle;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Packet shift register
  //////////////////////////////////////////////////

  // LSB goes first: start bit, node, dnr, length, payload
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      shift_r   <= {payload_i, len_i, dnr_i, node_i, 1'b1};
      masters_r <= masters_i;
    end
    else if (state_r == ser_shift)
    begin
      shift_r <= shift_r >> 1;
    end
  end

  // Line idles low outside a packet
  assign tag_data_o = (state_r == ser_shift) ? shift_r[0] : 1'b0;
  assign tag_en_o   = (state_r == ser_shift) ? masters_r : '0;

endmodule

/* logic/tag_pkg.sv */
package tag_pkg;

  //////////////////////////////////////////////////
  // Tag network field widths
  //////////////////////////////////////////////////

  // 16 clients on the tag ring
  localparam int tag_lg_els_c            = 4;
  localparam int tag_lg_width_c          = 4;
  localparam int tag_max_payload_width_c = 8;
  localparam int tag_num_masters_c       = 2;
  localparam int tag_op_width_c          = 4;

  localparam int tag_entry_width_c = tag_op_width_c + tag_num_masters_c + tag_lg_els_c + 1
                                   + tag_lg_width_c + tag_max_payload_width_c;

  // Field positions inside a trace entry
  localparam int tag_payload_lsb_c = 0;
  localparam int tag_len_lsb_c     = tag_payload_lsb_c + tag_max_payload_width_c;
  localparam int tag_dnr_bit_c     = tag_len_lsb_c + tag_lg_width_c;
  localparam int tag_node_lsb_c    = tag_dnr_bit_c + 1;
  localparam int tag_masters_lsb_c = tag_node_lsb_c + tag_lg_els_c;
  localparam int tag_op_lsb_c      = tag_masters_lsb_c + tag_num_masters_c;

  // Start bit, node, data-not-reset and length precede the payload
  localparam int tag_pkt_hdr_width_c = 1 + tag_lg_els_c + 1 + tag_lg_width_c;
  localparam int tag_pkt_max_width_c = tag_pkt_hdr_width_c + tag_max_payload_width_c;
  localparam int tag_bit_cnt_width_c = $clog2(tag_pkt_max_width_c + 1);

  localparam int rom_addr_width_c     = 4;
  localparam int slowdown_ratio_c     = 4;
  localparam int slowdown_cnt_width_c = $clog2(slowdown_ratio_c);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [tag_lg_els_c-1:0]            tag_node_id_t;
  typedef logic [tag_lg_width_c-1:0]          tag_len_t;
  typedef logic [tag_max_payload_width_c-1:0] tag_payload_t;
  typedef logic [tag_num_masters_c-1:0]       tag_masters_t;
  typedef logic [tag_entry_width_c-1:0]       tag_entry_t;
  typedef logic [rom_addr_width_c-1:0]        rom_addr_t;
  typedef logic [tag_pkt_max_width_c-1:0]     tag_pkt_t;
  typedef logic [tag_bit_cnt_width_c-1:0]     tag_bit_cnt_t;
  typedef logic [slowdown_cnt_width_c-1:0]    slow_cnt_t;

  // Unlisted opcodes take the illegal-entry path
  typedef enum logic [tag_op_width_c-1:0] {
    op_wait   = 4'd0,
    op_send   = 4'd1,
    op_finish = 4'd3
  } tag_op_e;

  typedef enum logic [1:0] {
    st_fetch,
    st_send,
    st_wait,
    st_done
  } replay_state_e;

  typedef enum logic [1:0] {
    ser_idle,
    ser_shift,
    ser_gap
  } ser_state_e;

endpackage

/* logic/tag_trace_replay.sv */
module tag_trace_replay
  import tag_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         en_i,

  output rom_addr_t    rom_addr_o,
  input  tag_entry_t   rom_data_i,

  output logic         send_valid_o,
  output tag_masters_t send_masters_o,
  output tag_node_id_t send_node_o,
  output logic         send_dnr_o,
  output tag_len_t     send_len_o,
  output tag_payload_t send_payload_o,
  input  logic         send_ready_i,

  output logic         done_o,
  output logic         error_o
);

  replay_state_e state_r, state_n;
  rom_addr_t     addr_r, addr_n;
  tag_payload_t  wait_cnt_r, wait_cnt_n;
  logic          error_r, error_n;
  logic          done_r, done_n;

  tag_op_e       entry_op;
  tag_len_t      entry_len;
  tag_payload_t  entry_payload;
  logic          len_legal;

  //////////////////////////////////////////////////
  // Entry decode
  //////////////////////////////////////////////////

  assign entry_op      = tag_op_e'(rom_data_i[tag_op_lsb_c +: tag_op_width_c]);
  assign entry_len     = rom_data_i[tag_len_lsb_c +: tag_lg_width_c];
  assign entry_payload = rom_data_i[tag_payload_lsb_c +: tag_max_payload_width_c];

  // Only lengths from 1 to the payload width go out on the wire
  assign len_legal = (entry_len != '0)
                  && (entry_len <= tag_len_t'(tag_max_payload_width_c));

  // Address holds during a send, so the ROM word stays stable
  assign send_masters_o = rom_data_i[tag_masters_lsb_c +: tag_num_masters_c];
  assign send_node_o    = rom_data_i[tag_node_lsb_c +: tag_lg_els_c];
  assign send_dnr_o     = rom_data_i[tag_dnr_bit_c];
  assign send_len_o     = entry_len;
  assign send_payload_o = entry_payload;
  assign send_valid_o   = (state_r == st_send);

  assign rom_addr_o = addr_r;
  assign done_o     = done_r;
  assign error_o    = error_r;

  //////////////////////////////////////////////////
  // Replay FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_n    = state_r;
    addr_n     = addr_r;
    wait_cnt_n = wait_cnt_r;
    error_n    = error_r;
    done_n     = done_r;

    case (state_r)
      st_fetch:
      begin
        // Stalled replay holds the current entry
        if (en_i)
        begin
          case (entry_op)
            op_wait:
            begin
              addr_n     = addr_r + 1'b1;
              wait_cnt_n = entry_payload;
              if (entry_payload != '0)
              begin
                state_n = st_wait;
              end
            end
            op_send:
            begin
              if (len_legal)
              begin
                state_n = st_send;
              end
              else
              begin
                error_n = 1'b1;
                addr_n  = addr_r + 1'b1;
              end
            end
            op_finish:
            begin
              state_n = st_done;
              done_n  = 1'b1;
            end
            default:
            begin
              error_n = 1'b1;
              addr_n  = addr_r + 1'b1;
            end
          endcase
        end
      end

      st_send:
      begin
        // Valid stays up until the serializer takes it
        if (send_ready_i)
        begin
          state_n = st_fetch;
          addr_n  = addr_r + 1'b1;
        end
      end

      st_wait:
      begin
        if (en_i)
        begin
          wait_cnt_n = wait_cnt_r - 1'b1;
          if (wait_cnt_r == tag_payload_t'(1))
          begin
            state_n = st_fetch;
          end
        end
      end

      st_done:
      begin
        state_n = st_done;
      end

      default:
      begin
        state_n = st_fetch;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r    <= st_fetch;
      addr_r     <= '0;
      wait_cnt_r <= '0;
      error_r    <= 1'b0;
      done_r     <= 1'b0;
    end
    else
    begin
      state_r    <= state_n;
      addr_r     <= addr_n;
      wait_cnt_r <= wait_cnt_n;
      error_r    <= error_n;
      done_r     <= done_n;
    end
  end

endmodule

/* logic/tag_trace_rom.sv */
module tag_trace_rom
  import tag_pkg::*;
(
  input  rom_addr_t  rom_addr_i,
  output tag_entry_t rom_data_o
);

  // Packs fields in entry order, opcode at the top
  function automatic tag_entry_t make_entry
  (
    input tag_op_e      op,
    input tag_masters_t masters,
    input tag_node_id_t node,
    input logic         dnr,
    input tag_len_t     len,
    input tag_payload_t payload
  );
    return {op, masters, node, dnr, len, payload};
  endfunction

  //////////////////////////////////////////////////
  // Boot trace
  //////////////////////////////////////////////////

  always_comb
  begin
    case (rom_addr_i)
      // Reset pulse to node 2
      4'd0:
        rom_data_o = make_entry(op_send, 2'b01, 4'd2, 1'b0, 4'd1, 8'h01);
      // Full byte of data to node 2
      4'd1:
        rom_data_o = make_entry(op_send, 2'b01, 4'd2, 1'b1, 4'd8, 8'ha5);
      // Let the client settle
      4'd2:
        rom_data_o = make_entry(op_wait, 2'b00, 4'd0, 1'b0, 4'd0, 8'd5);
      // Broadcast on both masters
      4'd3:
        rom_data_o = make_entry(op_send, 2'b11, 4'd9, 1'b1, 4'd5, 8'h16);
      // Malformed, 12 bits is wider than any payload
      4'd4:
        rom_data_o = make_entry(op_send, 2'b01, 4'd6, 1'b1, 4'd12, 8'hff);
      4'd5:
        rom_data_o = make_entry(op_send, 2'b10, 4'd15, 1'b1, 4'd3, 8'h05);
      4'd6:
        rom_data_o = make_entry(op_finish, 2'b00, 4'd0, 1'b0, 4'd0, 8'h00);
      // Anything past the end also finishes
      default:
        rom_data_o = make_entry(op_finish, 2'b00, 4'd0, 1'b0, 4'd0, 8'h00);
    endcase
  end

endmodule

/* tag_gateway.f */
logic/tag_pkg.sv
logic/tag_trace_rom.sv
logic/tag_trace_replay.sv
logic/tag_packet_serializer.sv
logic/tag_clock_slowdown.sv
logic/tag_gateway.sv
bench/tag_gateway_tb.sv
